// File: bp_defines.svh
// Size macros for the predictor counter table, target buffer, pending queue and word width
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// ==================================================
// Branch predictor sizing
// ==================================================

// Number of 2-bit counters in the gshare table, must be a power of two
`define BP_TABLE_SIZE 1024

// Number of direct-mapped target buffer entries
`define BP_BTB_ENTRIES 64

// Number of predictions that can wait for execute at once
`define BP_QUEUE_DEPTH 8

// Processor word width
`define BP_XLEN 32

`endif

// File: cpu_types_pkg.sv
// Processor-wide word and instruction address types
`include "bp_defines.svh"

package cpu_types_pkg;

    // ==================================================
    // Basic machine words
    // ==================================================

    // One machine word, used for instruction addresses and branch targets
    typedef logic [`BP_XLEN-1:0] data_word_t;

    // Instructions are word aligned, so the two low address bits
    // carry no information for indexing
    localparam int INSTR_ALIGN_BITS = 2;

endpackage : cpu_types_pkg

// File: predictor_pkg.sv
// Predictor types for counters, history, table and buffer indices and pending records
`include "bp_defines.svh"

package predictor_pkg;
    import cpu_types_pkg::*;

    // ==================================================
    // Widths derived from the size macros
    // ==================================================

    localparam int TABLE_INDEX_W = $clog2(`BP_TABLE_SIZE);
    localparam int BTB_INDEX_W   = $clog2(`BP_BTB_ENTRIES);
    localparam int QUEUE_PTR_W   = $clog2(`BP_QUEUE_DEPTH);

    // Saturating counter, the high bit is the taken guess
    typedef logic [1:0] counter_t;

    // Counter table index and the global history that is hashed into it
    typedef logic [TABLE_INDEX_W-1:0] table_index_t;
    typedef logic [TABLE_INDEX_W-1:0] history_t;

    // Target buffer index, taken from the low word-address bits
    typedef logic [BTB_INDEX_W-1:0] btb_index_t;

    // One in-flight prediction waiting for its branch to resolve
    typedef struct packed {
        logic         pred_taken;
        table_index_t index;
        data_word_t   target;
    } pending_t;

endpackage : predictor_pkg

// File: resolve_if.sv
// Interface carrying the execute-stage branch resolution to the predictor and target buffer
`timescale 1ns/1ps

interface resolve_if import cpu_types_pkg::*; ();

    // One-cycle strobe, high when execute has resolved a branch
    logic       valid;
    // Outcome of a conditional branch
    logic       taken;
    // Unconditional jump, always counts as taken
    logic       jump;
    // Address of the resolved branch
    data_word_t pc;
    // Target computed by execute
    data_word_t target;

    // Execute side drives every field
    modport exu (output valid, taken, jump, pc, target);

    // The predictor only needs the outcome and the real target
    modport predictor (input valid, taken, jump, target);

    // The target buffer also needs the branch address to place the entry
    modport btb (input valid, taken, jump, pc, target);

endinterface : resolve_if

// File: branch_target_buffer.sv
// Direct-mapped tagged branch target buffer with combinational lookup and taken-branch update
`timescale 1ns/1ps
`include "bp_defines.svh"

module branch_target_buffer
    import cpu_types_pkg::*;
    import predictor_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       lookup_valid_i,
    input  data_word_t lookup_pc_i,
    output logic       hit_o,
    output data_word_t target_o,
    resolve_if.btb     res
);

    // Tag covers every address bit above the index
    localparam int TAG_LSB = BTB_INDEX_W + INSTR_ALIGN_BITS;
    localparam int TAG_W   = `BP_XLEN - TAG_LSB;

    // ==================================================
    // Entry storage
    // ==================================================

    logic             valid_q  [`BP_BTB_ENTRIES];
    logic [TAG_W-1:0] tag_q    [`BP_BTB_ENTRIES];
    data_word_t       target_q [`BP_BTB_ENTRIES];

    btb_index_t       rd_index;
    logic [TAG_W-1:0] rd_tag;
    btb_index_t       wr_index;
    logic [TAG_W-1:0] wr_tag;
    logic             learn;

    // ==================================================
    // Lookup
    // ==================================================

    // Index comes from the word address, tag from the bits above it
    assign rd_index = lookup_pc_i[TAG_LSB-1:INSTR_ALIGN_BITS];
    assign rd_tag   = lookup_pc_i[`BP_XLEN-1:TAG_LSB];

    // A hit needs a live fetch, a filled entry and a matching tag
    assign hit_o    = lookup_valid_i & valid_q[rd_index] & (tag_q[rd_index] == rd_tag);

    // Target is only meaningful while hit_o is high
    assign target_o = target_q[rd_index];

    // ==================================================
    // Update from execute
    // ==================================================

    // Only branches that actually redirect are worth remembering
    assign learn    = res.valid & (res.taken | res.jump);
    assign wr_index = res.pc[TAG_LSB-1:INSTR_ALIGN_BITS];
    assign wr_tag   = res.pc[`BP_XLEN-1:TAG_LSB];

    // Valid bits start cleared so nothing hits before it is learned
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (learn) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    // A newer branch that aliases to the same slot simply replaces it
    always_ff @(posedge clk_i) begin
        if (learn) begin
            tag_q[wr_index]    <= wr_tag;
            target_q[wr_index] <= res.target;
        end
    end

endmodule : branch_target_buffer

// File: predictor_unit.sv
// Gshare direction predictor with global history, counter table, pending queue and mispredict check
`timescale 1ns/1ps
`include "bp_defines.svh"

module predictor_unit
    import cpu_types_pkg::*;
    import predictor_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  logic        predict_i,
    input  data_word_t  fetch_pc_i,
    input  data_word_t  btb_target_i,
    resolve_if.predictor res,
    output logic        prediction_o,
    output logic        mispredicted_o
);

    typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;

    // ==================================================
    // Global history and hashed index
    // ==================================================

    history_t     history_q;
    table_index_t hashed_index;
    logic         actual_taken;

    // Jumps always redirect, so they count as taken everywhere
    assign actual_taken = res.taken | res.jump;

    // Shift in every resolved outcome, even ones that had no record
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            history_q <= '0;
        end else if (res.valid) begin
            history_q <= {history_q[TABLE_INDEX_W-2:0], actual_taken};
        end
    end

    // Word address bits hashed with the history select the counter
    assign hashed_index = history_q ^ fetch_pc_i[TABLE_INDEX_W+INSTR_ALIGN_BITS-1:INSTR_ALIGN_BITS];

    // ==================================================
    // Pending queue control
    // ==================================================

    queue_ptr_t wr_ptr_q;
    queue_ptr_t rd_ptr_q;
    queue_ptr_t rd_ptr_inc;
    logic       empty_q;
    logic       push;
    logic       pop;
    logic       clear;

    // A stalled or flushed fetch still gets a guess but leaves no record
    assign push       = predict_i & ~stall_i & ~flush_i;

    // Resolutions with nothing pending belong to branches that missed the buffer
    assign pop        = res.valid & ~empty_q;

    // Anything younger than a wrong guess is on the wrong path
    assign clear      = mispredicted_o | flush_i;
    assign rd_ptr_inc = rd_ptr_q + 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            empty_q  <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_inc;
            end
            // Simultaneous push and pop leaves the fill level unchanged
            case ({push, pop})
                2'b10:   empty_q <= 1'b0;
                2'b01:   empty_q <= (rd_ptr_inc == wr_ptr_q);
                default: empty_q <= empty_q;
            endcase
        end
    end

    // ==================================================
    // Pending queue storage
    // ==================================================

    pending_t queue_q [`BP_QUEUE_DEPTH];
    pending_t head;

    always_ff @(posedge clk_i) begin
        if (push) begin
            queue_q[wr_ptr_q] <= '{pred_taken: prediction_o,
                                   index:      hashed_index,
                                   target:     btb_target_i};
        end
    end

    // Oldest record, compared against the branch that execute resolves
    assign head = queue_q[rd_ptr_q];

    // ==================================================
    // Counter table
    // ==================================================

    counter_t counter_q [`BP_TABLE_SIZE];
    counter_t head_counter;
    counter_t counter_next;

    // The upper counter bit is the direction guess
    assign prediction_o = counter_q[hashed_index][1];

    // Step the counter of the resolved record, saturating at both ends
    always_comb begin
        head_counter = counter_q[head.index];
        if (actual_taken) begin
            counter_next = (head_counter == 2'b11) ? head_counter : head_counter + 2'd1;
        end else begin
            counter_next = (head_counter == 2'b00) ? head_counter : head_counter - 2'd1;
        end
    end

    // Every counter starts weakly not taken
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BP_TABLE_SIZE; i++) begin
                counter_q[i] <= 2'd1;
            end
        end else if (pop) begin
            counter_q[head.index] <= counter_next;
        end
    end

    // ==================================================
    // Misprediction detection
    // ==================================================

    // Wrong direction, or right direction but the buffer pointed elsewhere
    // (target only matters when the branch actually redirected)
    assign mispredicted_o = pop & ((actual_taken != head.pred_taken) |
                                   (actual_taken & (res.target != head.target)));

endmodule : predictor_unit

// File: branch_predict_top.sv
// Branch prediction front end top level joining the target buffer, predictor and resolution bus
`timescale 1ns/1ps

module branch_predict_top
    import cpu_types_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       stall_i,
    input  logic       flush_i,
    input  logic       fetch_valid_i,
    input  data_word_t fetch_pc_i,
    input  logic       resolve_valid_i,
    input  logic       resolve_taken_i,
    input  logic       resolve_jump_i,
    input  data_word_t resolve_pc_i,
    input  data_word_t resolve_target_i,
    output logic       predict_valid_o,
    output logic       predict_taken_o,
    output data_word_t predict_target_o,
    output logic       mispredicted_o
);

    // ==================================================
    // Resolution bus from execute
    // ==================================================

    resolve_if res_bus ();

    assign res_bus.valid  = resolve_valid_i;
    assign res_bus.taken  = resolve_taken_i;
    assign res_bus.jump   = resolve_jump_i;
    assign res_bus.pc     = resolve_pc_i;
    assign res_bus.target = resolve_target_i;

    // ==================================================
    // Buffer and predictor
    // ==================================================

    // Buffer hit doubles as the request for a direction guess
    branch_target_buffer u_btb (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lookup_valid_i (fetch_valid_i),
        .lookup_pc_i    (fetch_pc_i),
        .hit_o          (predict_valid_o),
        .target_o       (predict_target_o),
        .res            (res_bus.btb)
    );

    // Direction is only meaningful alongside a buffer hit
    predictor_unit u_predictor (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .predict_i      (predict_valid_o),
        .fetch_pc_i     (fetch_pc_i),
        .btb_target_i   (predict_target_o),
        .res            (res_bus.predictor),
        .prediction_o   (predict_taken_o),
        .mispredicted_o (mispredicted_o)
    );

endmodule : branch_predict_top

// File: branch_predict_assertions.sv
// Concurrent checks on the predictor pending queue and misprediction strobe, bound into the predictor
`timescale 1ns/1ps

module branch_predict_assertions
    import predictor_pkg::*;
(
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   flush_i,
    input logic                   push_i,
    input logic                   empty_i,
    input logic [QUEUE_PTR_W-1:0] wr_ptr_i,
    input logic [QUEUE_PTR_W-1:0] rd_ptr_i,
    input logic                   res_valid_i,
    input logic                   mispredicted_i
);

    // Read by the testbench at the end of the run
    int unsigned failure_count = 0;
    logic        full;

    // Pointers meet both when empty and when full, the flag tells them apart
    assign full = !empty_i && (wr_ptr_i == rd_ptr_i);

    // ==================================================
    // Queue and misprediction properties
    // ==================================================

    // A misprediction only exists against a live resolution
    mispredict_needs_resolve: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mispredicted_i |-> res_valid_i)
    else begin
        $error("mispredicted_o high without a resolution");
        failure_count++;
    end

    // Fetch must stall before the queue overflows
    no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full)
    else begin
        $error("pending queue pushed while full");
        failure_count++;
    end

    // Wrong-path records are gone one cycle after a misprediction or flush
    empty_after_clear: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mispredicted_i || flush_i) |=> empty_i)
    else begin
        $error("pending queue not empty after misprediction or flush");
        failure_count++;
    end

endmodule : branch_predict_assertions

bind predictor_unit branch_predict_assertions u_assertions (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .push_i         (push),
    .empty_i        (empty_q),
    .wr_ptr_i       (wr_ptr_q),
    .rd_ptr_i       (rd_ptr_q),
    .res_valid_i    (res.valid),
    .mispredicted_i (mispredicted_o)
);

// File: branch_predict_tb.sv
// Testbench for the branch prediction front end with stimulus table, reference model and random phase
`timescale 1ns/1ps
`include "bp_defines.svh"

module branch_predict_tb
    import cpu_types_pkg::*;
    import predictor_pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int DRIVE_DELAY   = 1;
    localparam int SAMPLE_LEAD   = 1;
    localparam int TABLE_ROWS    = 24;
    localparam int RANDOM_CYCLES = 200;
    localparam int MARGIN_CYCLES = 40;
    localparam int TIMEOUT_NS    = (TABLE_ROWS + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD * 2;

    localparam data_word_t PC_A = 32'h0000_0100;
    // Sits in a different buffer slot from PC_A
    localparam data_word_t PC_X = 32'h0000_0308;

    typedef enum logic [2:0] {OP_IDLE, OP_LOOKUP, OP_STALL, OP_RESOLVE, OP_FLUSH} op_e;

    typedef struct packed {
        op_e        op;
        data_word_t addr;
        logic       taken;
        logic       jump;
        data_word_t target;
        logic       exp_hit;
        logic       exp_misp;
    } row_t;

    // Model copy of a pending record, plus the branch address for in-order resolution
    typedef struct packed {
        logic         pred;
        table_index_t index;
        data_word_t   target;
        data_word_t   pc;
    } model_rec_t;

    logic       clk_i, rst_n_i, stall_i, flush_i, fetch_valid_i;
    logic       resolve_valid_i, resolve_taken_i, resolve_jump_i;
    data_word_t fetch_pc_i, resolve_pc_i, resolve_target_i;
    logic       predict_valid_o, predict_taken_o, mispredicted_o;
    data_word_t predict_target_o;

    branch_predict_top dut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ==================================================
    // Reference model state
    // ==================================================

    counter_t   m_counter    [`BP_TABLE_SIZE];
    history_t   m_history;
    logic       m_btb_valid  [`BP_BTB_ENTRIES];
    data_word_t m_btb_pc     [`BP_BTB_ENTRIES];
    data_word_t m_btb_target [`BP_BTB_ENTRIES];
    model_rec_t m_queue[$];
    logic       exp_hit, exp_taken, exp_misp;
    data_word_t exp_target;
    logic [31:0] rand_state;

    // Learn PC_A, fill the history with ones through PC_X, then train PC_A
    // The last rows resolve against an empty queue, so a record left by the
    // stalled lookup or kept across the flush would show up as a wrong target
    row_t stimulus [TABLE_ROWS] = '{
        '{OP_LOOKUP,  PC_A, 1'b0, 1'b0, 32'h0,   1'b0, 1'b0},
        '{OP_RESOLVE, PC_A, 1'b1, 1'b0, 32'h200, 1'b0, 1'b0},
        '{OP_RESOLVE, PC_X, 1'b1, 1'b0, 32'h380, 1'b0, 1'b0},
        '{OP_RESOLVE, PC_X, 1'b1, 1'b0, 32'h380, 1'b0, 1'b0},
        '{OP_RESOLVE, PC_X, 1'b1, 1'b0, 32'h380, 1'b0, 1'b0},
        '{OP_RESOLVE, PC_X, 1'b0, 1'b1, 32'h380, 1'b0, 1'b0},
        '{OP_RESOLVE, PC_X, 1'b1, 1'b0, 32'h380, 1'b0, 1'b0},
        '{OP_RESOLVE, PC_X, 1'b1, 1'b0, 32'h380, 1'b0, 1'b0},
        '{OP_RESOLVE, PC_X, 1'b0, 1'b1, 32'h380, 1'b0, 1'b0},
        '{OP_RESOLVE, PC_X, 1'b1, 1'b0, 32'h380, 1'b0, 1'b0},
        '{OP_RESOLVE, PC_X, 1'b1, 1'b0, 32'h380, 1'b0, 1'b0},
        '{OP_LOOKUP,  PC_A, 1'b0, 1'b0, 32'h0,   1'b1, 1'b0},
        '{OP_RESOLVE, PC_A, 1'b1, 1'b0, 32'h200, 1'b0, 1'b1},
        '{OP_LOOKUP,  PC_A, 1'b0, 1'b0, 32'h0,   1'b1, 1'b0},
        '{OP_RESOLVE, PC_A, 1'b1, 1'b0, 32'h200, 1'b0, 1'b0},
        '{OP_LOOKUP,  PC_A, 1'b0, 1'b0, 32'h0,   1'b1, 1'b0},
        '{OP_LOOKUP,  PC_A, 1'b0, 1'b0, 32'h0,   1'b1, 1'b0},
        '{OP_RESOLVE, PC_A, 1'b1, 1'b0, 32'h200, 1'b0, 1'b0},
        '{OP_RESOLVE, PC_A, 1'b1, 1'b0, 32'h204, 1'b0, 1'b1},
        '{OP_STALL,   PC_A, 1'b0, 1'b0, 32'h0,   1'b1, 1'b0},
        '{OP_RESOLVE, PC_A, 1'b1, 1'b0, 32'h208, 1'b0, 1'b0},
        '{OP_LOOKUP,  PC_A, 1'b0, 1'b0, 32'h0,   1'b1, 1'b0},
        '{OP_FLUSH,   PC_A, 1'b0, 1'b0, 32'h0,   1'b0, 1'b0},
        '{OP_RESOLVE, PC_A, 1'b1, 1'b0, 32'h20c, 1'b0, 1'b0}
    };

    // ==================================================
    // Helpers and compare tasks
    // ==================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input data_word_t expected,
                              input data_word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic drive_idle();
        fetch_valid_i   = 1'b0;
        stall_i         = 1'b0;
        flush_i         = 1'b0;
        resolve_valid_i = 1'b0;
        resolve_taken_i = 1'b0;
        resolve_jump_i  = 1'b0;
    endtask

    // The buffer slot comes from address bits 7..2 and the tag from bits 31..8
    // The counter index is address bits 11..2 XORed with the history
    task automatic predict_outputs();
        btb_index_t   slot;
        table_index_t index;
        logic         actual;
        slot       = fetch_pc_i[7:2];
        index      = m_history ^ fetch_pc_i[11:2];
        exp_hit    = fetch_valid_i && m_btb_valid[slot] &&
                     (m_btb_pc[slot][31:8] == fetch_pc_i[31:8]);
        exp_taken  = m_counter[index][1];
        exp_target = m_btb_target[slot];
        actual     = resolve_taken_i | resolve_jump_i;
        exp_misp   = 1'b0;
        if (resolve_valid_i && m_queue.size() > 0) begin
            exp_misp = (actual != m_queue[0].pred) ||
                       (actual && (resolve_target_i != m_queue[0].target));
        end
    endtask

    task automatic compare_outputs();
        check_bit("predict_valid_o", exp_hit, predict_valid_o);
        if (exp_hit) begin
            check_bit("predict_taken_o", exp_taken, predict_taken_o);
            check_word("predict_target_o", exp_target, predict_target_o);
        end
        check_bit("mispredicted_o", exp_misp, mispredicted_o);
    endtask

    // Mirrors one clock edge with the predictions made before any counter moves
    task automatic update_model();
        model_rec_t head;
        model_rec_t rec;
        logic       actual;
        actual = resolve_taken_i | resolve_jump_i;
        rec    = '{exp_taken, m_history ^ fetch_pc_i[11:2], exp_target, fetch_pc_i};
        if (resolve_valid_i && m_queue.size() > 0) begin
            head = m_queue.pop_front();
            if (actual && m_counter[head.index] != 2'd3) begin
                m_counter[head.index] = m_counter[head.index] + 2'd1;
            end else if (!actual && m_counter[head.index] != 2'd0) begin
                m_counter[head.index] = m_counter[head.index] - 2'd1;
            end
        end
        if (exp_hit && !stall_i && !flush_i) begin
            m_queue.push_back(rec);
        end
        if (resolve_valid_i) begin
            m_history = {m_history[TABLE_INDEX_W-2:0], actual};
            if (actual) begin
                m_btb_valid[resolve_pc_i[7:2]]  = 1'b1;
                m_btb_pc[resolve_pc_i[7:2]]     = resolve_pc_i;
                m_btb_target[resolve_pc_i[7:2]] = resolve_target_i;
            end
        end
        if (exp_misp || flush_i) begin
            m_queue.delete();
        end
    endtask

    // ==================================================
    // Cycle sequencing
    // ==================================================

    task automatic apply_row(input row_t row);
        drive_idle();
        case (row.op)
            OP_LOOKUP, OP_STALL: begin
                fetch_valid_i = 1'b1;
                fetch_pc_i    = row.addr;
                stall_i       = (row.op == OP_STALL);
            end
            OP_RESOLVE: begin
                resolve_valid_i  = 1'b1;
                resolve_taken_i  = row.taken;
                resolve_jump_i   = row.jump;
                resolve_pc_i     = row.addr;
                resolve_target_i = row.target;
            end
            OP_FLUSH: flush_i = 1'b1;
            default: ;
        endcase
    endtask

    // Resolutions follow the model queue and missed branches only resolve while it is empty
    task automatic apply_random();
        logic [31:0] r;
        rand_state = xorshift32(rand_state);
        r          = rand_state;
        drive_idle();
        fetch_valid_i = r[0];
        fetch_pc_i    = 32'h1000 | {r[18:16], 2'b00} | {r[19], 8'h00};
        stall_i       = (r[2:1] == 2'b00) || (m_queue.size() == `BP_QUEUE_DEPTH);
        flush_i       = (r[7:3] == 5'd0);
        if (r[8] && m_queue.size() > 0) begin
            resolve_valid_i = 1'b1;
            resolve_pc_i    = m_queue[0].pc;
        end else if (r[13] && m_queue.size() == 0) begin
            resolve_valid_i = 1'b1;
            resolve_pc_i    = 32'h1000 | {r[22:20], 2'b00} | {r[23], 8'h00};
        end
        resolve_taken_i  = r[9];
        resolve_jump_i   = (r[11:10] == 2'b00);
        resolve_target_i = resolve_pc_i + (r[12] ? 32'h40 : 32'h80);
    endtask

    task automatic sample_cycle();
        #(CLK_PERIOD - DRIVE_DELAY - SAMPLE_LEAD);
        predict_outputs();
        compare_outputs();
    endtask

    task automatic advance_cycle();
        update_model();
        @(posedge clk_i);
        #(DRIVE_DELAY);
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================

    initial begin
        clk_i            = 1'b0;
        rst_n_i          = 1'b0;
        fetch_pc_i       = '0;
        resolve_pc_i     = '0;
        resolve_target_i = '0;
        drive_idle();
        rand_state = 32'd37;
        m_history  = '0;
        m_queue.delete();
        for (int i = 0; i < `BP_TABLE_SIZE; i++) begin
            m_counter[i] = 2'd1;
        end
        for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
            m_btb_valid[i] = 1'b0;
        end
        repeat (2) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_n_i = 1'b1;
        foreach (stimulus[i]) begin
            apply_row(stimulus[i]);
            sample_cycle();
            check_bit("predict_valid_o (table)", stimulus[i].exp_hit, predict_valid_o);
            check_bit("mispredicted_o (table)", stimulus[i].exp_misp, mispredicted_o);
            advance_cycle();
        end
        repeat (RANDOM_CYCLES) begin
            apply_random();
            sample_cycle();
            advance_cycle();
        end
        if (dut.u_predictor.u_assertions.failure_count != 0) begin
            $display("Bound assertions reported %0d failures",
                     dut.u_predictor.u_assertions.failure_count);
            abort_run();
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        abort_run();
    end

endmodule : branch_predict_tb

// File: vlog.f
+incdir+.
cpu_types_pkg.sv
predictor_pkg.sv
resolve_if.sv
branch_target_buffer.sv
predictor_unit.sv
branch_predict_top.sv
branch_predict_assertions.sv
branch_predict_tb.sv

// File: Bender.yml
package:
  name: branch_predict

sources:
  - include_dirs:
      - .
    files:
      - cpu_types_pkg.sv
      - predictor_pkg.sv
      - resolve_if.sv
      - branch_target_buffer.sv
      - predictor_unit.sv
      - branch_predict_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - branch_predict_assertions.sv
      - branch_predict_tb.sv
